// ==== bench/fm_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_clk_gen (
	output logic clk,
	output logic arst_n
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held over eight rising edges
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/fm_reg_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_properties (
	input wire                        clk,
	input wire                        arst_n,
	input wire                        clk_en,
	input wire                        busy,
	input wire fm_slot_pkg::fm_slot_t slot,
	input wire                        frame
);
	import fm_slot_pkg::*;

	logic [5:0] busy_cycles;
	// failed assertions so far
	int         fail_count = 0;

	// enabled cycles spent with a write pending
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy_cycles <= '0;
		else if (!busy)
			busy_cycles <= '0;
		else if (clk_en)
			busy_cycles <= busy_cycles + 6'd1;
	end

	// channel index 3 and 7 never show up
	slot_ch_ok: assert property (@(posedge clk) disable iff (!arst_n)
		slot.ch[1:0] != 2'b11)
		else begin
			fail_count++;
			$error("slot carries channel index 3 or 7");
		end

	// frame marks ch 0 op 0 and nothing else
	frame_ok: assert property (@(posedge clk) disable iff (!arst_n)
		frame == (slot == '0))
		else begin
			fail_count++;
			$error("frame does not match slot zero");
		end

	// a full pass at most before the command lands
	busy_bound: assert property (@(posedge clk) disable iff (!arst_n)
		busy_cycles <= slot_count)
		else begin
			fail_count++;
			$error("busy held longer than one slot pass");
		end

	busy_in_reset: assert property (@(posedge clk) !arst_n |-> !busy)
		else begin
			fail_count++;
			$error("busy high during reset");
		end

endmodule

bind fm_reg_top fm_reg_properties props0 (
	.clk   (clk),
	.arst_n(arst_n),
	.clk_en(clk_en),
	.busy  (busy),
	.slot  (slot),
	.frame (frame)
);

`default_nettype wire

// ==== bench/fm_reg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_tb;
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	wire           clk;
	wire           arst_n;
	logic          clk_en;
	logic          wr;
	logic [7:0]    addr;
	logic [7:0]    din;
	logic          part;
	logic          busy;
	logic          frame;
	fm_slot_t      slot;
	fm_op_params_t op_params;
	fm_ch_params_t ch_params;

	integer seed;
	// position 0..23 of the slot now shown
	int     exp_pos;

	// reference model
	fm_op_params_t op_m [slot_count];
	fm_ch_params_t ch_m [ch_stages];
	fm_freq_t      eff_freq_m [3];
	fm_fhi_t       lat_ch_m;
	fm_fhi_t       lat_eff_m;
	logic          eff_m;

	fm_clk_gen clk_gen0 (.clk(clk), .arst_n(arst_n));

	fm_reg_top dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.clk_en   (clk_en),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.part     (part),
		.busy     (busy),
		.slot     (slot),
		.frame    (frame),
		.op_params(op_params),
		.ch_params(ch_params)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_slot(input fm_slot_t got, input fm_slot_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch slot: got %h, expected %h", got, exp));
	endtask

	task automatic check_op(input fm_op_params_t got, input fm_op_params_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch op_params at pos %h: got %h, expected %h",
				exp_pos, got, exp));
	endtask

	task automatic check_ch(input fm_ch_params_t got, input fm_ch_params_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch ch_params at pos %h: got %h, expected %h",
				exp_pos, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// pass order 0 1 2 4 5 6
	function automatic fm_ch_t ch_at(input int p);
		return (p < 3) ? fm_ch_t'(p) : fm_ch_t'(p + 1);
	endfunction

	function automatic int ch_pos(input fm_ch_t c);
		return (c < 3'd3) ? int'(c) : int'(c) - 1;
	endfunction

	// field layout of the operator registers
	function automatic fm_op_params_t op_update(input fm_op_params_t r, input logic [3:0] grp,
		input logic [7:0] d);
		case (grp)
			4'h3: begin
				r.dt  = d[6:4];
				r.mul = d[3:0];
			end
			4'h4: r.tl = d[6:0];
			4'h5: begin
				r.ks = d[7:6];
				r.ar = d[4:0];
			end
			4'h6: begin
				r.amen = d[7];
				r.dr   = d[4:0];
			end
			4'h7: r.sr = d[4:0];
			4'h8: begin
				r.sl = d[7:4];
				r.rr = d[3:0];
			end
			4'h9: begin
				r.ssg_en = d[3];
				r.ssg_eg = d[2:0];
			end
			default: ;
		endcase
		return r;
	endfunction

	function automatic fm_ch_params_t ch_update(input fm_ch_params_t r, input logic [7:0] a,
		input logic [7:0] d, input fm_fhi_t hi);
		case ({a[7:2], 2'b00})
			addr_fnum_lo: r.freq = {hi, d};
			addr_fb_alg: begin
				r.fb  = d[5:3];
				r.alg = d[2:0];
			end
			addr_rl_ams_pms: begin
				r.rl  = d[7:6];
				r.ams = d[5:4];
				r.pms = d[2:0];
			end
			default: ;
		endcase
		return r;
	endfunction

	// writes that wait for their slot
	function automatic logic is_bound(input logic [7:0] a);
		if (a == addr_mode || a[1:0] == 2'b11)
			return 1'b0;
		if (a[7:4] >= 4'h3 && a[7:4] <= 4'h9)
			return 1'b1;
		return {a[7:2], 2'b00} inside {addr_fnum_lo, addr_fb_alg, addr_rl_ams_pms};
	endfunction

	function automatic logic rand_en();
		return ($random(seed) & 3) != 0;
	endfunction

	// mostly operator groups, some channel, latch, mode and stray addresses
	function automatic logic [7:0] pick_addr();
		int         cat;
		logic [7:0] r;
		logic [3:0] grp;
		cat = $random(seed) & 15;
		r   = $random(seed);
		grp = 4'h3 + 4'(r[7:4] % 4'd7);
		case (cat)
			8:       return addr_fnum_lo | r[1:0];
			9:       return addr_fb_alg | r[1:0];
			10:      return addr_rl_ams_pms | r[1:0];
			11:      return addr_fnum_hi | r[1:0];
			12:      return addr_eff_lo | r[1:0];
			13:      return addr_eff_hi | r[1:0];
			14:      return addr_mode;
			15:      return r;
			default: return {grp, r[3:0]};
		endcase
	endfunction

	// mode, latches and effect frequencies
	task automatic apply_immediate(input logic [7:0] a, input logic [7:0] d);
		if (a == addr_mode) begin
			eff_m = d[6];
		end else if (a[1:0] != 2'b11) begin
			case ({a[7:2], 2'b00})
				addr_fnum_hi: lat_ch_m = d[5:0];
				addr_eff_hi:  lat_eff_m = d[5:0];
				addr_eff_lo:  eff_freq_m[a[1:0]] = {lat_eff_m, d};
				default: ;
			endcase
		end
	endtask

	task automatic check_outputs();
		fm_slot_t      exp_s;
		fm_ch_params_t exp_ch;
		exp_s.op = fm_op_t'(exp_pos / ch_stages);
		exp_s.ch = ch_at(exp_pos % ch_stages);
		check_slot(slot, exp_s);
		check_bit("frame", frame, exp_pos == 0);
		check_op(op_params, op_m[exp_pos]);
		exp_ch = ch_m[exp_pos % ch_stages];
		// effect channel, operators 0 to 2
		if (eff_m && exp_s.ch == effect_ch && exp_s.op != 2'd3)
			exp_ch.freq = eff_freq_m[exp_s.op];
		check_ch(ch_params, exp_ch);
	endtask

	task automatic host_write(input logic [7:0] a, input logic [7:0] d, input logic p);
		logic       bound;
		logic       junk;
		logic [7:0] r;
		fm_fhi_t    hi;
		int         n;
		int         idx;
		bound = is_bound(a);
		// latch value seen by the command
		hi = lat_ch_m;
		@(posedge clk);
		wr     <= 1'b1;
		addr   <= a;
		din    <= d;
		part   <= p;
		clk_en <= rand_en();
		@(posedge clk);
		wr     <= 1'b0;
		clk_en <= rand_en();
		if (!bound)
			apply_immediate(a, d);
		@(negedge clk);
		check_bit("busy", busy, bound);
		if (bound) begin
			n    = 0;
			junk = 1'b0;
			while (busy) begin
				if (n == 200)
					report_failure("timeout: busy did not fall after a slot write");
				@(posedge clk);
				// stray strobe, busy is known to stay high for it
				if (junk) begin
					r     = $random(seed);
					wr   <= 1'b1;
					addr <= $random(seed);
					din  <= r;
					part <= r[0];
				end else begin
					wr <= 1'b0;
				end
				junk = !junk && (($random(seed) & 7) == 0);
				// hold the slot for one edge before a stray strobe
				clk_en <= junk ? 1'b0 : rand_en();
				n++;
				@(negedge clk);
			end
			@(posedge clk);
			clk_en <= rand_en();
			if (a[7:4] >= 4'h3 && a[7:4] <= 4'h9) begin
				idx = int'(a[3:2]) * ch_stages + ch_pos({p, a[1:0]});
				op_m[idx] = op_update(op_m[idx], a[7:4], d);
			end else begin
				idx = ch_pos({p, a[1:0]});
				ch_m[idx] = ch_update(ch_m[idx], a, d, hi);
			end
		end
	endtask

	// output checker, one look per enabled cycle
	initial begin : output_check
		int n;
		n       = 0;
		exp_pos = 0;
		@(negedge clk);
		while (!arst_n) begin
			if (n == 20)
				report_failure("timeout: reset was not released");
			@(negedge clk);
			n++;
		end
		forever begin
			// bound assertions count their failures
			if (dut0.props0.fail_count != 0)
				report_failure("a property assertion on the DUT failed");
			if (clk_en) begin
				check_outputs();
				exp_pos = (exp_pos + 1) % slot_count;
			end
			@(negedge clk);
		end
	end

	initial begin : stimulus
		int         n;
		logic [7:0] a;
		logic [7:0] d;
		logic [7:0] r;
		seed      = 9;
		wr        = 1'b0;
		addr      = '0;
		din       = '0;
		part      = 1'b0;
		clk_en    = 1'b0;
		lat_ch_m  = '0;
		lat_eff_m = '0;
		eff_m     = 1'b0;
		for (int i = 0; i < slot_count; i++) begin
			op_m[i]    = '0;
			op_m[i].tl = 7'h7f;
		end
		for (int i = 0; i < ch_stages; i++) begin
			ch_m[i]    = '0;
			ch_m[i].rl = 2'b11;
		end
		for (int i = 0; i < 3; i++)
			eff_freq_m[i] = '0;
		n = 0;
		@(negedge clk);
		while (!arst_n) begin
			if (n == 20)
				report_failure("timeout: reset was not released");
			@(negedge clk);
			n++;
		end
		// idle frames, reset values everywhere
		repeat (60) begin
			@(posedge clk);
			clk_en <= rand_en();
		end
		for (int i = 0; i < 400; i++) begin
			a = pick_addr();
			d = $random(seed);
			r = $random(seed);
			host_write(a, d, r[0]);
			// occasional gap between writes
			if (r[7:6] == 2'b00) begin
				repeat (r[3:1]) begin
					@(posedge clk);
					clk_en <= rand_en();
				end
			end
		end
		// one more pass to see the last writes
		repeat (60) begin
			@(posedge clk);
			clk_en <= rand_en();
		end
		@(negedge clk);
		if (dut0.props0.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure("a property assertion on the DUT failed");
		end
	end

endmodule

`default_nettype wire

// ==== design/fm_op_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_op_ram (
	input  wire                        clk,
	input  wire                        clk_en,
	input  wire fm_slot_pkg::fm_slot_t wr_slot,
	input  wire fm_slot_pkg::fm_slot_t rd_slot,
	input  wire fm_reg_pkg::fm_op_params_t data,
	output fm_reg_pkg::fm_op_params_t  q
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	fm_op_params_t mem [slot_count];

	// write the slot now passing
	always_ff @(posedge clk) begin
		if (clk_en)
			mem[slot_index(wr_slot)] <= data;
	end

	// fetch the coming slot, q lines up with cur one cycle later
	always_ff @(posedge clk) begin
		if (clk_en)
			q <= mem[slot_index(rd_slot)];
	end

endmodule

`default_nettype wire

// ==== design/fm_param_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_param_bank (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        clk_en,
	input  wire fm_reg_pkg::fm_wr_cmd_t cmd,
	input  wire                        pend,
	output logic                       applied,
	output fm_slot_pkg::fm_slot_t      slot,
	output logic                       frame,
	output fm_reg_pkg::fm_op_params_t  op_params,
	output fm_reg_pkg::fm_ch_params_t  ch_params
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	fm_slot_t      cur;
	fm_slot_t      nxt;
	fm_op_params_t op_q;
	fm_op_params_t op_base;
	fm_op_params_t op_new;
	fm_ch_params_t ch_q;
	fm_ch_params_t ch_new;
	logic          init;

	fm_slot_counter u_cnt (
		.clk   (clk),
		.arst_n(arst_n),
		.clk_en(clk_en),
		.cur   (cur),
		.next  (nxt),
		.frame (frame)
	);

	fm_op_ram u_ram (
		.clk    (clk),
		.clk_en (clk_en),
		.wr_slot(cur),
		.rd_slot(nxt),
		.data   (op_new),
		.q      (op_q)
	);

	fm_slot_delay #(
		.payload_t(fm_ch_params_t),
		.depth    (ch_stages),
		.rst_val  (ch_reset)
	) u_ch_line (
		.clk   (clk),
		.arst_n(arst_n),
		.clk_en(clk_en),
		.din   (ch_new),
		.dout  (ch_q)
	);

	// first frame after reset fills the ram with op_reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			init <= 1'b1;
		else if (clk_en && cur == fm_slot_t'{op: 2'd3, ch: last_ch})
			init <= 1'b0;
	end

	// ram contents not yet valid while filling
	assign op_base = init ? op_reset : op_q;

	// command meets its slot
	assign applied = pend && clk_en && (cur == cmd.slot);

	// operator fields
	always_comb begin
		op_new = op_base;
		if (applied) begin
			case (cmd.kind)
				cmd_dt_mul: begin
					op_new.dt  = cmd.data[6:4];
					op_new.mul = cmd.data[3:0];
				end
				cmd_tl: op_new.tl = cmd.data[6:0];
				cmd_ks_ar: begin
					op_new.ks = cmd.data[7:6];
					op_new.ar = cmd.data[4:0];
				end
				cmd_am_dr: begin
					op_new.amen = cmd.data[7];
					op_new.dr   = cmd.data[4:0];
				end
				cmd_sr: op_new.sr = cmd.data[4:0];
				cmd_sl_rr: begin
					op_new.sl = cmd.data[7:4];
					op_new.rr = cmd.data[3:0];
				end
				cmd_ssg: begin
					op_new.ssg_en = cmd.data[3];
					op_new.ssg_eg = cmd.data[2:0];
				end
				default: ;
			endcase
		end
	end

	// channel fields, back into the line
	always_comb begin
		ch_new = ch_q;
		if (applied) begin
			case (cmd.kind)
				// high part from the latch captured with the command
				cmd_fnum_lo: ch_new.freq = {cmd.hi, cmd.data};
				cmd_fb_alg: begin
					ch_new.fb  = cmd.data[5:3];
					ch_new.alg = cmd.data[2:0];
				end
				cmd_rl_ams_pms: begin
					ch_new.rl  = cmd.data[7:6];
					ch_new.ams = cmd.data[5:4];
					ch_new.pms = cmd.data[2:0];
				end
				default: ;
			endcase
		end
	end

	// records as they stood before this pass
	assign slot      = cur;
	assign op_params = op_base;
	assign ch_params = ch_q;

endmodule

`default_nettype wire

// ==== design/fm_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_decode (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    wr,
	input  wire  [7:0]             addr,
	input  wire  [7:0]             din,
	input  wire                    part,
	input  wire                    applied,
	output fm_reg_pkg::fm_wr_cmd_t cmd,
	output logic                   pend,
	output logic                   busy,
	output logic                   effect,
	output fm_reg_pkg::fm_wr_cmd_t eff_wr
);
	import fm_reg_pkg::*;

	fm_cmd_kind_t kind;
	fm_wr_cmd_t   new_cmd;
	fm_fhi_t      lat_ch;
	fm_fhi_t      lat_eff;
	logic         hit_mode;
	logic         hit_lat_ch;
	logic         hit_lat_eff;
	logic         go;
	logic         slot_bound;

	// address classification
	always_comb begin
		kind        = cmd_none;
		hit_mode    = 1'b0;
		hit_lat_ch  = 1'b0;
		hit_lat_eff = 1'b0;
		// mode register sits at a low field of 3, so test it first
		if (addr == addr_mode) begin
			hit_mode = 1'b1;
		end else if (addr[1:0] != 2'b11) begin
			// operator groups, one per high nibble
			case ({addr[7:4], 4'h0})
				addr_dt_mul: kind = cmd_dt_mul;
				addr_tl:     kind = cmd_tl;
				addr_ks_ar:  kind = cmd_ks_ar;
				addr_am_dr:  kind = cmd_am_dr;
				addr_sr:     kind = cmd_sr;
				addr_sl_rr:  kind = cmd_sl_rr;
				addr_ssg:    kind = cmd_ssg;
				default:     ;
			endcase
			// channel groups, four addresses each
			case ({addr[7:2], 2'b00})
				addr_fnum_lo:    kind = cmd_fnum_lo;
				addr_fnum_hi:    hit_lat_ch = 1'b1;
				addr_eff_lo:     kind = cmd_effect_lo;
				addr_eff_hi:     hit_lat_eff = 1'b1;
				addr_fb_alg:     kind = cmd_fb_alg;
				addr_rl_ams_pms: kind = cmd_rl_ams_pms;
				default:         ;
			endcase
		end
	end

	// strobes during busy are lost
	assign go = wr && !busy;
	// everything except effect frequencies waits for its slot
	assign slot_bound = (kind != cmd_none) && (kind != cmd_effect_lo);

	always_comb begin
		new_cmd.kind = kind;
		// channel records pass with operator 0
		if (kind inside {cmd_fnum_lo, cmd_fb_alg, cmd_rl_ams_pms})
			new_cmd.slot.op = 2'd0;
		else
			new_cmd.slot.op = addr[3:2];
		new_cmd.slot.ch = {part, addr[1:0]};
		new_cmd.data    = din;
		new_cmd.hi      = (kind == cmd_effect_lo) ? lat_eff : lat_ch;
		new_cmd.eff_op  = addr[1:0];
	end

	// effect low byte goes straight to the output side
	always_comb begin
		eff_wr = new_cmd;
		if (!(go && kind == cmd_effect_lo))
			eff_wr.kind = cmd_none;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend    <= 1'b0;
			effect  <= 1'b0;
			lat_ch  <= '0;
			lat_eff <= '0;
		end else begin
			// bank took the command this cycle
			if (applied)
				pend <= 1'b0;
			if (go) begin
				if (slot_bound)
					pend <= 1'b1;
				if (hit_mode)
					effect <= din[6];
				if (hit_lat_ch)
					lat_ch <= din[5:0];
				if (hit_lat_eff)
					lat_eff <= din[5:0];
			end
		end
	end

	// held command, only valid with pend
	always_ff @(posedge clk) begin
		if (go && slot_bound)
			cmd <= new_cmd;
	end

	assign busy = pend;

endmodule

`default_nettype wire

// ==== design/fm_reg_pkg.sv ====
`default_nettype none

package fm_reg_pkg;

	// operator parameters, one record per slot
	typedef struct packed {
		logic [6:0] tl;
		logic [2:0] dt;
		logic [3:0] mul;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amen;
		logic [4:0] dr;
		logic [4:0] sr;
		logic [3:0] sl;
		logic [3:0] rr;
		logic       ssg_en;
		logic [2:0] ssg_eg;
	} fm_op_params_t;

	// block and frequency number
	typedef struct packed {
		logic [2:0]  block;
		logic [10:0] fnum;
	} fm_freq_t;

	// channel parameters
	typedef struct packed {
		fm_freq_t   freq;
		logic [2:0] fb;
		logic [2:0] alg;
		logic [1:0] rl;
		logic [1:0] ams;
		logic [2:0] pms;
	} fm_ch_params_t;

	// block plus fnum high bits as written to the latch
	typedef logic [5:0] fm_fhi_t;

	typedef enum logic [3:0] {
		cmd_none,
		cmd_dt_mul,
		cmd_tl,
		cmd_ks_ar,
		cmd_am_dr,
		cmd_sr,
		cmd_sl_rr,
		cmd_ssg,
		cmd_fnum_lo,
		cmd_fb_alg,
		cmd_rl_ams_pms,
		cmd_effect_lo
	} fm_cmd_kind_t;

	typedef struct packed {
		fm_cmd_kind_t          kind;
		fm_slot_pkg::fm_slot_t slot;
		logic [7:0]            data;
		fm_fhi_t               hi;
		logic [1:0]            eff_op;
	} fm_wr_cmd_t;

	// register map
	localparam logic [7:0] addr_mode       = 8'h27;
	localparam logic [7:0] addr_dt_mul     = 8'h30;
	localparam logic [7:0] addr_tl         = 8'h40;
	localparam logic [7:0] addr_ks_ar      = 8'h50;
	localparam logic [7:0] addr_am_dr      = 8'h60;
	localparam logic [7:0] addr_sr         = 8'h70;
	localparam logic [7:0] addr_sl_rr      = 8'h80;
	localparam logic [7:0] addr_ssg        = 8'h90;
	localparam logic [7:0] addr_fnum_lo    = 8'hA0;
	localparam logic [7:0] addr_fnum_hi    = 8'hA4;
	localparam logic [7:0] addr_eff_lo     = 8'hA8;
	localparam logic [7:0] addr_eff_hi     = 8'hAC;
	localparam logic [7:0] addr_fb_alg     = 8'hB0;
	localparam logic [7:0] addr_rl_ams_pms = 8'hB4;

	// silent operator, total level at maximum attenuation
	localparam fm_op_params_t op_reset = '{tl: '1, default: '0};
	// both outputs on
	localparam fm_ch_params_t ch_reset = '{rl: 2'b11, default: '0};

endpackage

`default_nettype wire

// ==== design/fm_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_top (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       clk_en,
	input  wire                       wr,
	input  wire  [7:0]                addr,
	input  wire  [7:0]                din,
	input  wire                       part,
	output logic                      busy,
	output fm_slot_pkg::fm_slot_t     slot,
	output logic                      frame,
	output fm_reg_pkg::fm_op_params_t op_params,
	output fm_reg_pkg::fm_ch_params_t ch_params
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	fm_wr_cmd_t    cmd;
	fm_wr_cmd_t    eff_wr;
	logic          pend;
	logic          applied;
	logic          effect;
	logic          bank_frame;
	fm_slot_t      bank_slot;
	fm_op_params_t bank_op;
	fm_ch_params_t bank_ch;

	// host writes in
	fm_reg_decode u_decode (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (wr),
		.addr   (addr),
		.din    (din),
		.part   (part),
		.applied(applied),
		.cmd    (cmd),
		.pend   (pend),
		.busy   (busy),
		.effect (effect),
		.eff_wr (eff_wr)
	);

	// slot-rate storage
	fm_param_bank u_bank (
		.clk      (clk),
		.arst_n   (arst_n),
		.clk_en   (clk_en),
		.cmd      (cmd),
		.pend     (pend),
		.applied  (applied),
		.slot     (bank_slot),
		.frame    (bank_frame),
		.op_params(bank_op),
		.ch_params(bank_ch)
	);

	// effect frequency select
	fm_slot_out u_out (
		.clk      (clk),
		.arst_n   (arst_n),
		.effect   (effect),
		.eff_wr   (eff_wr),
		.slot     (bank_slot),
		.op_in    (bank_op),
		.ch_in    (bank_ch),
		.frame    (bank_frame),
		.cur_slot (slot),
		.op_params(op_params),
		.ch_params(ch_params),
		.cur_frame(frame)
	);

endmodule

`default_nettype wire

// ==== design/fm_slot_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_slot_counter (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   clk_en,
	output fm_slot_pkg::fm_slot_t cur,
	output fm_slot_pkg::fm_slot_t next,
	output logic                  frame
);
	import fm_slot_pkg::*;

	// channel order 0 1 2 4 5 6, operator steps after 6
	always_comb begin
		next = cur;
		if (cur.ch == last_ch) begin
			next.ch = '0;
			next.op = cur.op + 2'd1;
		end else if (cur.ch[1:0] == 2'b10) begin
			// skip index 3
			next.ch = cur.ch + 3'd2;
		end else begin
			next.ch = cur.ch + 3'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cur   <= '0;
			frame <= 1'b1;
		end else if (clk_en) begin
			cur   <= next;
			frame <= (next == '0);
		end
	end

endmodule

`default_nettype wire

// ==== design/fm_slot_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_slot_delay #(
	parameter type      payload_t = logic,
	parameter int       depth     = 2,
	parameter payload_t rst_val   = '0
) (
	input  wire           clk,
	input  wire           arst_n,
	input  wire           clk_en,
	input  wire payload_t din,
	output payload_t      dout
);

	payload_t line [depth];

	// whole line preset so every channel starts from rst_val
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++)
				line[i] <= rst_val;
		end else if (clk_en) begin
			line[0] <= din;
			for (int i = 1; i < depth; i++)
				line[i] <= line[i-1];
		end
	end

	// oldest entry comes back around
	assign dout = line[depth-1];

endmodule

`default_nettype wire

// ==== design/fm_slot_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_slot_out (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         effect,
	input  wire fm_reg_pkg::fm_wr_cmd_t  eff_wr,
	input  wire fm_slot_pkg::fm_slot_t   slot,
	input  wire fm_reg_pkg::fm_op_params_t op_in,
	input  wire fm_reg_pkg::fm_ch_params_t ch_in,
	input  wire                         frame,
	output fm_slot_pkg::fm_slot_t       cur_slot,
	output fm_reg_pkg::fm_op_params_t   op_params,
	output fm_reg_pkg::fm_ch_params_t   ch_params,
	output logic                        cur_frame
);
	import fm_slot_pkg::*;
	import fm_reg_pkg::*;

	fm_freq_t eff_freq [3];
	logic     use_eff;

	// per-operator frequencies of the effect channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 3; i++)
				eff_freq[i] <= '0;
		end else if (eff_wr.kind == cmd_effect_lo) begin
			eff_freq[eff_wr.eff_op] <= {eff_wr.hi, eff_wr.data};
		end
	end

	// operator 3 keeps the channel frequency
	assign use_eff = effect && (slot.ch == effect_ch) && (slot.op != 2'd3);

	always_comb begin
		ch_params = ch_in;
		if (use_eff)
			ch_params.freq = eff_freq[slot.op];
	end

	assign cur_slot  = slot;
	assign op_params = op_in;
	assign cur_frame = frame;

endmodule

`default_nettype wire

// ==== design/fm_slot_pkg.sv ====
`default_nettype none

package fm_slot_pkg;

	// channel index, 3 and 7 never occur
	typedef logic [2:0] fm_ch_t;
	// operator index
	typedef logic [1:0] fm_op_t;

	// one time slot of the frame
	typedef struct packed {
		fm_op_t op;
		fm_ch_t ch;
	} fm_slot_t;

	// operator slots per frame
	localparam int slot_count = 24;
	// one stage per channel
	localparam int ch_stages = 6;
	// channel with the special frequency mode
	localparam fm_ch_t effect_ch = 3'd2;
	// last channel of a pass, operator steps after it
	localparam fm_ch_t last_ch = 3'd6;

	// dense memory index 0..23
	function automatic logic [4:0] slot_index(fm_slot_t s);
		logic [2:0] pos;
		// channels 4..6 fold onto 3..5
		pos = s.ch[2] ? s.ch - 3'd1 : s.ch;
		return ({3'b000, s.op} * 5'd6) + {2'b00, pos};
	endfunction

endpackage

`default_nettype wire

// ==== list.f ====
design/fm_slot_pkg.sv
design/fm_reg_pkg.sv
design/fm_reg_decode.sv
design/fm_slot_counter.sv
design/fm_op_ram.sv
design/fm_slot_delay.sv
design/fm_param_bank.sv
design/fm_slot_out.sv
design/fm_reg_top.sv
bench/fm_clk_gen.sv
bench/fm_reg_properties.sv
bench/fm_reg_tb.sv
